// File: rvseed_pkg.sv
// rvseed core shared types: widths, opcodes, selector encodings and bundles
`default_nettype none

package rvseed_pkg;

    typedef logic [31:0] xlen_t;      // data word
    typedef logic [31:0] addr_t;      // byte address
    typedef logic [31:0] inst_t;      // raw instruction word
    typedef logic [4:0]  reg_addr_t;  // register index

    localparam addr_t RESET_PC = 32'h0000_0000;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam inst_t EBREAK_INST = 32'h0010_0073;  // only legal system word

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_e;
    typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} src_b_e;
    typedef enum logic [1:0] {IMM_I, IMM_U, IMM_B, IMM_J} imm_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_op_e;

    typedef enum logic [1:0] {ST_FETCH, ST_EXEC, ST_HALT} core_state_e;

    // decoded control, one instruction at a time
    typedef struct packed {
        logic      reg_wen;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        imm_op_e   imm_op;
        alu_op_e   alu_op;
        src_a_e    src_a;
        src_b_e    src_b;
        br_op_e    br_op;
        logic      jump;     // jal
        logic      jalr;
        logic      ebreak;
        logic      illegal;
    } ctrl_t;

    // what one retired instruction did
    typedef struct packed {
        addr_t     pc;
        inst_t     inst;
        reg_addr_t rd;
        xlen_t     wdata;
    } retire_t;

endpackage

`default_nettype wire

// File: fetch_unit.sv
// fetch unit: pc register, next-pc select and wishbone instruction fetch sequencing
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
    input  logic              clk,
    input  logic              reset,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output rvseed_pkg::addr_t wb_adr,
    input  rvseed_pkg::inst_t wb_dat_i,
    input  logic              wb_ack,
    input  rvseed_pkg::ctrl_t ctrl,
    input  rvseed_pkg::xlen_t imm,
    input  rvseed_pkg::xlen_t alu_res,
    input  logic              br_taken,
    output rvseed_pkg::inst_t inst,
    output rvseed_pkg::addr_t pc,
    output logic              exec,
    output logic              halted,
    output logic              unknown_code
);
    import rvseed_pkg::*;

    core_state_e state;
    logic        req;      // cyc/stb register
    logic        stop;     // ebreak or illegal in exec
    addr_t       next_pc;

    assign wb_cyc = req;
    assign wb_stb = req;
    assign wb_we  = 1'b0;  // fetch only, never writes
    assign wb_adr = pc;

    assign stop   = ctrl.ebreak || ctrl.illegal;
    assign exec   = (state == ST_EXEC) && !stop;
    assign halted = (state == ST_HALT);

    // jalr target comes from the alu sum, lsb forced low
    always_comb begin
        if (ctrl.jalr) begin
            next_pc = {alu_res[31:1], 1'b0};
        end else if (ctrl.jump || br_taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ST_FETCH;
            req          <= 1'b0;
            pc           <= RESET_PC;
            unknown_code <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (!req) begin
                        req <= 1'b1;             // first request out of reset
                    end else if (wb_ack) begin
                        req   <= 1'b0;           // drop in the cycle after ack
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (stop) begin
                        state        <= ST_HALT;
                        unknown_code <= ctrl.illegal;
                    end else begin
                        pc    <= next_pc;
                        req   <= 1'b1;           // next request right away
                        state <= ST_FETCH;
                    end
                end
                default: begin
                    req <= 1'b0;                 // parked until reset
                end
            endcase
        end
    end

    // instruction latch
    always_ff @(posedge clk) begin
        if (state == ST_FETCH && req && wb_ack) begin
            inst <= wb_dat_i;
        end
    end

endmodule

`default_nettype wire

// File: ctrl.sv
// instruction decoder: opcode/funct fields to control bundle, flags illegal words
`timescale 1ns/1ns
`default_nettype none

module ctrl (
    input  rvseed_pkg::inst_t inst,
    output rvseed_pkg::ctrl_t ctrl
);
    import rvseed_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       rd_nz;   // x0 destinations never write

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd_nz  = |inst[11:7];

    always_comb begin
        ctrl        = '0;
        ctrl.rs1    = inst[19:15];
        ctrl.rs2    = inst[24:20];
        ctrl.rd     = inst[11:7];
        ctrl.imm_op = IMM_I;
        ctrl.alu_op = ALU_ADD;
        ctrl.src_a  = SRC_A_RS1;
        ctrl.src_b  = SRC_B_RS2;
        ctrl.br_op  = BR_NONE;

        case (opcode)
            OP_REG: begin
                ctrl.reg_wen = rd_nz;
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  ctrl.alu_op = ALU_ADD;
                        3'b111:  ctrl.alu_op = ALU_AND;
                        3'b110:  ctrl.alu_op = ALU_OR;
                        3'b100:  ctrl.alu_op = ALU_XOR;
                        3'b010:  ctrl.alu_op = ALU_SLT;
                        3'b011:  ctrl.alu_op = ALU_SLTU;
                        default: ctrl.illegal = 1'b1;  // shifts
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    ctrl.alu_op = ALU_SUB;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            OP_IMM: begin
                ctrl.reg_wen = rd_nz;
                ctrl.src_b   = SRC_B_IMM;
                case (funct3)
                    3'b000:  ctrl.alu_op = ALU_ADD;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    default: ctrl.illegal = 1'b1;      // sltiu and shifts
                endcase
            end
            OP_LUI: begin
                ctrl.reg_wen = rd_nz;
                ctrl.imm_op  = IMM_U;
                ctrl.src_a   = SRC_A_ZERO;
                ctrl.src_b   = SRC_B_IMM;
                ctrl.alu_op  = ALU_PASS_B;
            end
            OP_AUIPC: begin
                ctrl.reg_wen = rd_nz;
                ctrl.imm_op  = IMM_U;
                ctrl.src_a   = SRC_A_PC;
                ctrl.src_b   = SRC_B_IMM;
            end
            OP_JAL: begin
                ctrl.reg_wen = rd_nz;
                ctrl.imm_op  = IMM_J;
                ctrl.src_a   = SRC_A_PC;
                ctrl.src_b   = SRC_B_FOUR;    // link value, same as write data
                ctrl.jump    = 1'b1;
            end
            OP_JALR: begin
                ctrl.reg_wen = rd_nz;
                ctrl.src_b   = SRC_B_IMM;     // rs1 + imm is the target
                ctrl.jalr    = 1'b1;
                ctrl.illegal = (funct3 != 3'b000);
            end
            OP_BRANCH: begin
                ctrl.imm_op = IMM_B;
                case (funct3)
                    3'b000:  ctrl.br_op = BR_EQ;
                    3'b001:  ctrl.br_op = BR_NE;
                    3'b100:  ctrl.br_op = BR_LT;
                    3'b101:  ctrl.br_op = BR_GE;
                    3'b110:  ctrl.br_op = BR_LTU;
                    3'b111:  ctrl.br_op = BR_GEU;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            OP_SYSTEM: begin
                if (inst == EBREAK_INST) begin
                    ctrl.ebreak = 1'b1;
                end else begin
                    ctrl.illegal = 1'b1;      // ecall, csr ops
                end
            end
            default: begin
                ctrl.illegal = 1'b1;          // loads, stores, fence, anything else
            end
        endcase
    end

endmodule

`default_nettype wire

// File: imm_gen.sv
// immediate generator: sign-extended i, u, b and j immediates
`timescale 1ns/1ns
`default_nettype none

module imm_gen (
    input  rvseed_pkg::inst_t   inst,
    input  rvseed_pkg::imm_op_e imm_op,
    output rvseed_pkg::xlen_t   imm
);
    import rvseed_pkg::*;

    always_comb begin
        case (imm_op)
            IMM_I: imm = {{20{inst[31]}}, inst[31:20]};
            IMM_U: imm = {inst[31:12], 12'b0};
            // b and j offsets are in halfwords, bit 0 always zero
            IMM_B: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                          inst[11:8], 1'b0};
            IMM_J: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                          inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: reg_file.sv
// integer register file: 32 x 32, two combinational reads, one write, x0 tied to zero
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wen,
    input  rvseed_pkg::reg_addr_t waddr,
    input  rvseed_pkg::reg_addr_t raddr1,
    input  rvseed_pkg::reg_addr_t raddr2,
    input  rvseed_pkg::xlen_t     wdata,
    output rvseed_pkg::xlen_t     rdata1,
    output rvseed_pkg::xlen_t     rdata2
);
    import rvseed_pkg::*;

    xlen_t regs [0:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads zero whatever is stored
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: alu.sv
// alu: operand select, arithmetic/logic ops and branch condition evaluation
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  rvseed_pkg::ctrl_t ctrl,
    input  rvseed_pkg::xlen_t rdata1,
    input  rvseed_pkg::xlen_t rdata2,
    input  rvseed_pkg::xlen_t imm,
    input  rvseed_pkg::addr_t pc,
    output rvseed_pkg::xlen_t alu_res,
    output logic              br_taken
);
    import rvseed_pkg::*;

    xlen_t op_a;
    xlen_t op_b;

    always_comb begin
        case (ctrl.src_a)
            SRC_A_PC:   op_a = pc;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = rdata1;
        endcase

        case (ctrl.src_b)
            SRC_B_IMM:  op_b = imm;
            SRC_B_FOUR: op_b = 32'd4;
            default:    op_b = rdata2;
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
            default:    alu_res = op_b;   // pass_b, lui
        endcase
    end

    // compare always on the register values, not the muxed operands
    always_comb begin
        case (ctrl.br_op)
            BR_EQ:   br_taken = (rdata1 == rdata2);
            BR_NE:   br_taken = (rdata1 != rdata2);
            BR_LT:   br_taken = ($signed(rdata1) < $signed(rdata2));
            BR_GE:   br_taken = ($signed(rdata1) >= $signed(rdata2));
            BR_LTU:  br_taken = (rdata1 < rdata2);
            BR_GEU:  br_taken = (rdata1 >= rdata2);
            default: br_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: rvseed_top.sv
// rvseed core top: fetch, decode, register file, immediates and alu with wishbone and retire ports
`timescale 1ns/1ns
`default_nettype none

module rvseed_top (
    input  logic                clk,
    input  logic                reset,
    output logic                wb_cyc,
    output logic                wb_stb,
    output rvseed_pkg::addr_t   wb_adr,
    output logic                wb_we,
    input  rvseed_pkg::inst_t   wb_dat_i,
    input  logic                wb_ack,
    output logic                retire_valid,
    output rvseed_pkg::retire_t retire,
    output logic                halted,
    output logic                unknown_code
);
    import rvseed_pkg::*;

    inst_t inst;
    addr_t pc;
    logic  exec;
    ctrl_t dec_ctrl;
    xlen_t imm;
    xlen_t rdata1;
    xlen_t rdata2;
    xlen_t alu_res;
    logic  br_taken;
    xlen_t wdata;
    logic  reg_wen;

    // link value for jal/jalr, alu result for the rest
    assign wdata   = (dec_ctrl.jump || dec_ctrl.jalr) ? pc + 32'd4 : alu_res;
    assign reg_wen = exec && dec_ctrl.reg_wen;

    assign retire_valid = exec;

    always_comb begin
        retire.pc    = pc;
        retire.inst  = inst;
        retire.rd    = dec_ctrl.reg_wen ? dec_ctrl.rd : '0;  // no dest reports x0
        retire.wdata = dec_ctrl.reg_wen ? wdata : '0;
    end

    fetch_unit u_fetch_unit (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack),
        .ctrl         (dec_ctrl),
        .imm          (imm),
        .alu_res      (alu_res),
        .br_taken     (br_taken),
        .inst         (inst),
        .pc           (pc),
        .exec         (exec),
        .halted       (halted),
        .unknown_code (unknown_code)
    );

    ctrl u_ctrl (
        .inst (inst),
        .ctrl (dec_ctrl)
    );

    imm_gen u_imm_gen (
        .inst   (inst),
        .imm_op (dec_ctrl.imm_op),
        .imm    (imm)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .wen    (reg_wen),
        .waddr  (dec_ctrl.rd),
        .raddr1 (dec_ctrl.rs1),
        .raddr2 (dec_ctrl.rs2),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    alu u_alu (
        .ctrl     (dec_ctrl),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .imm      (imm),
        .pc       (pc),
        .alu_res  (alu_res),
        .br_taken (br_taken)
    );

endmodule

`default_nettype wire

// File: tb_wb_rom.sv
// wishbone classic instruction rom model with random wait states and the test programs
`timescale 1ns/1ns
`default_nettype none

module tb_wb_rom (
    input  logic              clk,
    input  logic              reset,
    input  logic              prog_sel,   // 0 main program, 1 illegal-word program
    input  logic              cyc,
    input  logic              stb,
    input  rvseed_pkg::addr_t adr,
    output rvseed_pkg::inst_t dat,
    output logic              ack
);
    import rvseed_pkg::*;

    inst_t main_prog [0:63];
    inst_t bad_prog  [0:63];
    int    wait_left;
    logic  busy;

    function automatic inst_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic inst_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t b_type(input logic [12:0] off, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    assign dat = prog_sel ? bad_prog[adr[7:2]] : main_prog[adr[7:2]];

    initial begin
        void'($urandom(12));
        ack        = 1'b0;
        busy       = 1'b0;
        wait_left  = 0;
        // unused words are addi x0, x0, index
        for (int i = 0; i < 64; i++) begin
            main_prog[i] = {12'(i), 5'd0, 3'd0, 5'd0, OP_IMM};
            bad_prog[i]  = {12'(i), 5'd0, 3'd0, 5'd0, OP_IMM};
        end
        main_prog[0]  = {20'h12345, 5'd1, OP_LUI};
        main_prog[1]  = i_type(12'hffb, 5'd0, 3'd0, 5'd2, OP_IMM);     // x2 = -5
        main_prog[2]  = i_type(12'd7, 5'd0, 3'd0, 5'd3, OP_IMM);
        main_prog[3]  = r_type(7'h00, 5'd3, 5'd1, 3'd0, 5'd4);          // add
        main_prog[4]  = r_type(7'h20, 5'd2, 5'd3, 3'd0, 5'd5);          // sub
        main_prog[5]  = r_type(7'h00, 5'd3, 5'd2, 3'd7, 5'd6);
        main_prog[6]  = r_type(7'h00, 5'd3, 5'd2, 3'd6, 5'd7);
        main_prog[7]  = r_type(7'h00, 5'd3, 5'd2, 3'd4, 5'd8);
        main_prog[8]  = r_type(7'h00, 5'd3, 5'd2, 3'd2, 5'd9);          // slt
        main_prog[9]  = r_type(7'h00, 5'd3, 5'd2, 3'd3, 5'd10);         // sltu
        main_prog[10] = i_type(12'h0f0, 5'd2, 3'd7, 5'd11, OP_IMM);
        main_prog[11] = i_type(12'hf00, 5'd3, 3'd6, 5'd12, OP_IMM);
        main_prog[12] = i_type(12'h555, 5'd2, 3'd4, 5'd13, OP_IMM);
        main_prog[13] = i_type(12'd0, 5'd2, 3'd2, 5'd14, OP_IMM);       // slti
        main_prog[14] = {20'h00001, 5'd15, OP_AUIPC};
        main_prog[15] = i_type(12'd5, 5'd3, 3'd0, 5'd0, OP_IMM);        // write to x0
        main_prog[16] = r_type(7'h00, 5'd3, 5'd0, 3'd0, 5'd16);         // reads x0
        main_prog[17] = b_type(13'd8, 5'd3, 5'd3, 3'd0);                // beq taken
        main_prog[18] = i_type(12'd1, 5'd0, 3'd0, 5'd17, OP_IMM);
        main_prog[19] = b_type(13'd8, 5'd3, 5'd3, 3'd1);                // bne not taken
        main_prog[20] = b_type(13'd8, 5'd3, 5'd2, 3'd4);                // blt taken
        main_prog[21] = i_type(12'd2, 5'd0, 3'd0, 5'd17, OP_IMM);
        main_prog[22] = b_type(13'd8, 5'd3, 5'd2, 3'd5);                // bge not taken
        main_prog[23] = b_type(13'd8, 5'd2, 5'd3, 3'd6);                // bltu taken
        main_prog[24] = i_type(12'd3, 5'd0, 3'd0, 5'd17, OP_IMM);
        main_prog[25] = b_type(13'd8, 5'd2, 5'd3, 3'd7);                // bgeu not taken
        main_prog[26] = {1'b0, 10'd4, 1'b0, 8'd0, 5'd18, OP_JAL};       // jal +8
        main_prog[27] = i_type(12'd4, 5'd0, 3'd0, 5'd17, OP_IMM);
        main_prog[28] = {20'h00000, 5'd19, OP_AUIPC};
        main_prog[29] = i_type(12'd16, 5'd19, 3'd0, 5'd20, OP_JALR);
        main_prog[30] = i_type(12'd5, 5'd0, 3'd0, 5'd17, OP_IMM);
        main_prog[31] = i_type(12'd6, 5'd0, 3'd0, 5'd17, OP_IMM);
        main_prog[32] = i_type(12'd1, 5'd20, 3'd0, 5'd21, OP_IMM);
        main_prog[33] = EBREAK_INST;
        bad_prog[0]   = i_type(12'd3, 5'd0, 3'd0, 5'd1, OP_IMM);
        bad_prog[1]   = 32'hffff_ffff;
    end

    // one ack per request after 0..3 wait cycles
    always @(posedge clk) begin
        #1;
        if (reset || !(cyc && stb)) begin
            busy = 1'b0;
            ack  = 1'b0;
        end else if (!busy) begin
            busy      = 1'b1;
            wait_left = int'($urandom_range(3));
            ack       = (wait_left == 0);
        end else if (!ack) begin
            wait_left--;
            ack = (wait_left == 0);
        end
    end

endmodule

`default_nettype wire

// File: tb_rvseed_top.sv
// testbench for the rvseed core with reference model, bus and retire checks and two program runs
`timescale 1ns/1ns
`default_nettype none

module tb_rvseed_top;
    import rvseed_pkg::*;

    localparam int PROG_LEN        = 34;
    localparam int WATCHDOG_CYCLES = 2 * (PROG_LEN * 6 + 40);

    logic    clk;
    logic    reset;
    logic    prog_sel;
    logic    wb_cyc;
    logic    wb_stb;
    logic    wb_we;
    logic    wb_ack;
    addr_t   wb_adr;
    inst_t   wb_dat;
    logic    retire_valid;
    retire_t retire;
    logic    halted;
    logic    unknown_code;

    xlen_t model_regs [0:31];
    addr_t model_pc;
    int    retired;
    int    value_errors;
    int    protocol_errors;
    logic  prev_acked;
    logic  prev_wait;
    addr_t prev_adr;
    logic  first_req_seen;
    logic  halt_pending;
    logic  halt_illegal;
    logic  reset_seen;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // reset as the core sampled it at the last edge
    always @(posedge clk) reset_seen <= reset;

    rvseed_top i_rvseed_top (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_we        (wb_we),
        .wb_dat_i     (wb_dat),
        .wb_ack       (wb_ack),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted),
        .unknown_code (unknown_code)
    );

    tb_wb_rom i_rom (
        .clk      (clk),
        .reset    (reset),
        .prog_sel (prog_sel),
        .cyc      (wb_cyc),
        .stb      (wb_stb),
        .adr      (wb_adr),
        .dat      (wb_dat),
        .ack      (wb_ack)
    );

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        value_errors++;
        $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic report_protocol(input string msg);
        protocol_errors++;
        $display("protocol error at %0t: %s", $time, msg);
    endtask

    // instruction-level model following the rv32i rules
    task automatic model_execute(input inst_t w, output reg_addr_t rd, output xlen_t val,
                                 output addr_t npc, output logic stop, output logic bad);
        logic [2:0] f3;
        xlen_t      a;
        xlen_t      b;
        xlen_t      ii;
        xlen_t      ui;
        xlen_t      bi;
        xlen_t      ji;
        logic       take;
        f3   = w[14:12];
        a    = model_regs[w[19:15]];
        b    = model_regs[w[24:20]];
        ii   = {{20{w[31]}}, w[31:20]};
        ui   = {w[31:12], 12'h000};
        bi   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        ji   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        rd   = w[11:7];
        val  = '0;
        npc  = model_pc + 32'd4;
        bad  = 1'b0;
        take = 1'b0;
        case (w[6:0])
            7'b0110111: val = ui;
            7'b0010111: val = model_pc + ui;
            7'b1101111: begin
                val = model_pc + 32'd4;
                npc = model_pc + ji;
            end
            7'b1100111: begin
                val = model_pc + 32'd4;
                npc = (a + ii) & ~32'd1;
                bad = (f3 != 3'd0);
            end
            7'b1100011: begin
                rd = '0;
                case (f3)
                    3'd0:    take = (a == b);
                    3'd1:    take = (a != b);
                    3'd4:    take = ($signed(a) < $signed(b));
                    3'd5:    take = ($signed(a) >= $signed(b));
                    3'd6:    take = (a < b);
                    3'd7:    take = (a >= b);
                    default: bad = 1'b1;
                endcase
                if (take) npc = model_pc + bi;
            end
            7'b0010011: begin
                case (f3)
                    3'd0:    val = a + ii;
                    3'd7:    val = a & ii;
                    3'd6:    val = a | ii;
                    3'd4:    val = a ^ ii;
                    3'd2:    val = {31'b0, $signed(a) < $signed(ii)};
                    default: bad = 1'b1;
                endcase
            end
            7'b0110011: begin
                if (w[31:25] == 7'h00) begin
                    case (f3)
                        3'd0:    val = a + b;
                        3'd7:    val = a & b;
                        3'd6:    val = a | b;
                        3'd4:    val = a ^ b;
                        3'd2:    val = {31'b0, $signed(a) < $signed(b)};
                        3'd3:    val = {31'b0, a < b};
                        default: bad = 1'b1;
                    endcase
                end else if (w[31:25] == 7'h20 && f3 == 3'd0) begin
                    val = a - b;
                end else begin
                    bad = 1'b1;
                end
            end
            default: bad = (w != 32'h0010_0073);   // only ebreak among the rest
        endcase
        stop = bad || (w == 32'h0010_0073);
        if (rd == '0) val = '0;
    endtask

    always @(negedge clk) begin
        reg_addr_t exp_rd;
        xlen_t     exp_val;
        addr_t     exp_npc;
        logic      stop;
        logic      bad;
        inst_t     w;
        if (reset) begin
            if (reset_seen) begin
                assert (!wb_cyc && !wb_stb && !retire_valid && !halted && !unknown_code)
                    else report_protocol("core outputs active during reset");
            end
            for (int i = 0; i < 32; i++) model_regs[i] = '0;
            model_pc       = RESET_PC;
            retired        = 0;
            prev_acked     = 1'b0;
            prev_wait      = 1'b0;
            first_req_seen = 1'b0;
            halt_pending   = 1'b0;
            halt_illegal   = 1'b0;
        end else begin
            if (wb_cyc) assert (!wb_we) else report_protocol("write enable on a fetch");
            if (wb_cyc && !first_req_seen) begin
                first_req_seen = 1'b1;
                assert (wb_adr == RESET_PC) else report_value("wb_adr", wb_adr, RESET_PC);
            end
            if (prev_wait) begin
                assert (wb_cyc && wb_stb && wb_adr == prev_adr)
                    else report_protocol("request changed during wait states");
            end
            if (halted) assert (!wb_cyc) else report_protocol("bus cycle while halted");
            if (!halt_pending) assert (!halted) else report_protocol("halted without cause");
            assert (!unknown_code || halted) else report_protocol("unknown_code without halt");
            if (halted) begin
                assert (unknown_code == halt_illegal)
                    else report_value("unknown_code", 32'(unknown_code), 32'(halt_illegal));
            end
            assert (!retire_valid || prev_acked) else report_protocol("retire without ack");
            if (prev_acked) begin
                w = prog_sel ? i_rom.bad_prog[model_pc[7:2]] : i_rom.main_prog[model_pc[7:2]];
                model_execute(w, exp_rd, exp_val, exp_npc, stop, bad);
                if (stop) begin
                    halt_pending = 1'b1;
                    halt_illegal = bad;
                    assert (!retire_valid) else report_protocol("retire on a halting word");
                end else begin
                    assert (retire_valid) else report_protocol("no retire one cycle after ack");
                    assert (retire.pc == model_pc)
                        else report_value("retire.pc", retire.pc, model_pc);
                    assert (retire.inst == w) else report_value("retire.inst", retire.inst, w);
                    assert (retire.rd == exp_rd)
                        else report_value("retire.rd", 32'(retire.rd), 32'(exp_rd));
                    assert (retire.wdata == exp_val)
                        else report_value("retire.wdata", retire.wdata, exp_val);
                    if (exp_rd != '0) model_regs[exp_rd] = exp_val;
                    model_pc = exp_npc;
                    retired++;
                end
            end
            if (wb_cyc && wb_stb && wb_ack) begin
                assert (wb_adr == model_pc) else report_value("wb_adr", wb_adr, model_pc);
            end
            prev_acked = wb_cyc && wb_stb && wb_ack;
            prev_wait  = wb_stb && !wb_ack;
            prev_adr   = wb_adr;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, core did not halt", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        value_errors    = 0;
        protocol_errors = 0;
        reset           = 1'b1;
        prog_sel        = 1'b0;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        wait (halted);
        @(negedge clk);
        assert (!unknown_code) else report_protocol("unknown_code raised at ebreak");
        assert (retired == 27) else report_value("retired count", retired, 27);
        repeat (8) @(posedge clk);   // bus must stay idle

        // second run with an illegal word after one addi
        #1 reset = 1'b1;
        prog_sel = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        wait (halted);
        @(negedge clk);
        assert (unknown_code) else report_protocol("unknown_code not raised on illegal word");
        assert (retired == 1) else report_value("retired count", retired, 1);
        repeat (4) @(posedge clk);

        $display("checks done: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
rvseed_pkg.sv
fetch_unit.sv
ctrl.sv
imm_gen.sv
reg_file.sv
alu.sv
rvseed_top.sv
tb_wb_rom.sv
tb_rvseed_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rvseed testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_rvseed_top -o sim_rvseed
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_rvseed)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" <<< "$output"; then
    exit 0
fi
exit 1
